// ==== fp_pkg.sv ====
package fp_pkg;

	// ======================================================================
	// 27-bit float format
	// ======================================================================

	// Word layout: sign, biased exponent, fraction with hidden one
	localparam int FP_W   = 27;
	localparam int EXP_W  = 8;
	localparam int FRAC_W = 18;
	localparam int EXP_BIAS = 127;

	// Largest exponent whose value still fits a 16-bit signed integer
	localparam int FP_MAX_EXP_INT = 141;

	// Inverse square root seed, taken from the raw word
	localparam logic [FP_W-1:0] INV_SQRT_MAGIC = 27'd49920718;

	// 1.5 used in the Newton step
	localparam logic [FP_W-1:0] FP_THREE_HALVES = {1'b0, 8'd127, 18'h20000};

	// Pipeline depths in clock cycles
	localparam int INV_SQRT_LATENCY = 5;
	localparam int ADD_LATENCY      = 2;

	typedef struct packed {
		logic              sign;
		logic [EXP_W-1:0]  exp;
		logic [FRAC_W-1:0] frac;
	} fp_fields_t;

	// Integer view sits in the low 16 bits
	typedef struct packed {
		logic [FP_W-17:0]   pad;
		logic signed [15:0] value;
	} fp_int_t;

	// Operand word, read as a float or as an integer
	typedef union packed {
		fp_fields_t fields;
		fp_int_t    int_view;
	} fp_word_u;

endpackage

// ==== fpu_regs_pkg.sv ====
package fpu_regs_pkg;

	// ======================================================================
	// APB register map
	// ======================================================================

	// Byte addresses
	localparam logic [4:0] REG_OPA    = 5'h00;
	localparam logic [4:0] REG_OPB    = 5'h04;
	localparam logic [4:0] REG_CTRL   = 5'h08;
	localparam logic [4:0] REG_STATUS = 5'h0C;
	localparam logic [4:0] REG_RESULT = 5'h10;

	// Operation code written to CTRL
	typedef enum logic [2:0] {
		OP_ADD      = 3'd0,
		OP_SUB      = 3'd1,
		OP_MUL      = 3'd2,
		OP_INV_SQRT = 3'd3,
		OP_INT2FP   = 3'd4,
		OP_FP2INT   = 3'd5
	} fpu_op_e;

	// STATUS bit positions
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;

endpackage

// ==== fpu_op_if.sv ====
`timescale 1ns/10ps

// One operation from the register block to the execution unit
interface fpu_op_if;

	// Issue side
	logic                  start;
	fpu_regs_pkg::fpu_op_e op;
	fp_pkg::fp_word_u      a;
	fp_pkg::fp_word_u      b;

	// Completion side
	logic                  busy;
	logic                  done;
	fp_pkg::fp_word_u      result;

	// Register block issues, reads back
	modport regs (output start, op, a, b, input busy, done, result);

	// Execution unit takes the op, reports busy and result
	modport exec (input start, op, a, b, output busy, done, result);

endinterface

// ==== fp_mul.sv ====
`timescale 1ns/10ps

module fp_mul (
	input  fp_pkg::fp_word_u a,
	input  fp_pkg::fp_word_u b,
	output fp_pkg::fp_word_u prod
);
	localparam int EW     = fp_pkg::EXP_W;
	localparam int FW     = fp_pkg::FRAC_W;
	localparam int MANT_W = FW + 1;
	// Room for the exponent sum plus carry
	localparam int SUM_W  = EW + 2;

	logic [MANT_W-1:0]   a_mant;
	logic [MANT_W-1:0]   b_mant;
	logic [2*MANT_W-1:0] mant_prod;
	logic                carry;
	logic [SUM_W-1:0]    exp_sum;
	logic [EW-1:0]       exp_out;
	logic [FW-1:0]       frac_out;
	logic                underflow;

	// Restore hidden ones
	assign a_mant    = {1'b1, a.fields.frac};
	assign b_mant    = {1'b1, b.fields.frac};
	assign mant_prod = a_mant * b_mant;

	// Product lies in [1,4), top bit means one place of normalize
	assign carry    = mant_prod[2*MANT_W-1];
	assign frac_out = carry ? mant_prod[2*MANT_W-2 -: FW] : mant_prod[2*MANT_W-3 -: FW];

	// Biased sum, less one bias
	assign exp_sum   = SUM_W'(a.fields.exp) + SUM_W'(b.fields.exp) + SUM_W'(carry);
	assign exp_out   = EW'(exp_sum - SUM_W'(fp_pkg::EXP_BIAS));
	assign underflow = (exp_sum <= SUM_W'(fp_pkg::EXP_BIAS));

	always_comb begin
		prod = '0;
		// Zero operand or too small a result gives zero
		if (a.fields.exp != '0 && b.fields.exp != '0 && !underflow) begin
			prod = {a.fields.sign ^ b.fields.sign, exp_out, frac_out};
		end
	end

endmodule

// ==== fp_add.sv ====
`timescale 1ns/10ps

module fp_add (
	input  logic             iCLK,
	input  fp_pkg::fp_word_u a,
	input  fp_pkg::fp_word_u b,
	output fp_pkg::fp_word_u sum
);
	localparam int EW     = fp_pkg::EXP_W;
	localparam int FW     = fp_pkg::FRAC_W;
	localparam int MANT_W = FW + 1;
	// Carry bit, mantissa, then guard bits for the shifted operand
	localparam int ACC_W  = 1 + MANT_W + FW;
	localparam int LZ_W   = $clog2(ACC_W + 1);

	// Stage one, alignment
	logic [MANT_W-1:0] a_mant;
	logic [MANT_W-1:0] b_mant;
	logic              a_larger;
	logic [EW-1:0]     exp_diff;
	logic [EW-1:0]     larger_exp;
	logic [ACC_W-1:0]  big_acc;
	logic [ACC_W-1:0]  small_acc;
	logic [ACC_W-1:0]  pre_sum;

	// Stage one registers
	logic [ACC_W-1:0]  s1_sum;
	logic [EW-1:0]     s1_exp;
	logic              s1_sign;
	logic              s1_a_zero;
	logic              s1_b_zero;
	fp_pkg::fp_word_u  s1_a;
	fp_pkg::fp_word_u  s1_b;

	// Stage two, normalize
	logic [LZ_W-1:0]   lz;
	logic [ACC_W-1:0]  norm;
	logic [EW-1:0]     norm_exp;
	logic              underflow;

	// Leading zero count, all zero gives ACC_W
	function automatic logic [LZ_W-1:0] lead_zeros(input logic [ACC_W-1:0] v);
		logic [LZ_W-1:0] n;
		n = LZ_W'(ACC_W);
		for (int i = 0; i < ACC_W; i++) begin
			if (v[i])
				n = LZ_W'(ACC_W - 1 - i);
		end
		return n;
	endfunction

	// ======================================================================
	// Stage one
	// ======================================================================

	always_comb begin
		a_mant   = {1'b1, a.fields.frac};
		b_mant   = {1'b1, b.fields.frac};
		// Magnitude order, ties go to B
		a_larger = (a.fields.exp > b.fields.exp) ||
			((a.fields.exp == b.fields.exp) && (a_mant > b_mant));
		if (a_larger) begin
			larger_exp = a.fields.exp;
			exp_diff   = a.fields.exp - b.fields.exp;
			big_acc    = {1'b0, a_mant, {FW{1'b0}}};
			small_acc  = {1'b0, b_mant, {FW{1'b0}}} >> exp_diff;
		end else begin
			larger_exp = b.fields.exp;
			exp_diff   = b.fields.exp - a.fields.exp;
			big_acc    = {1'b0, b_mant, {FW{1'b0}}};
			small_acc  = {1'b0, a_mant, {FW{1'b0}}} >> exp_diff;
		end
		// Unlike signs subtract the smaller magnitude
		if (a.fields.sign ^ b.fields.sign)
			pre_sum = big_acc - small_acc;
		else
			pre_sum = big_acc + small_acc;
	end

	always_ff @(posedge iCLK) begin
		s1_sum    <= pre_sum;
		s1_exp    <= larger_exp;
		s1_sign   <= a_larger ? a.fields.sign : b.fields.sign;
		s1_a_zero <= (a.fields.exp == '0);
		s1_b_zero <= (b.fields.exp == '0);
		s1_a      <= a;
		s1_b      <= b;
	end

	// ======================================================================
	// Stage two
	// ======================================================================

	// Leading one moves to the top bit, one below is the first fraction bit
	assign lz        = lead_zeros(s1_sum);
	assign norm      = s1_sum << lz;
	assign norm_exp  = s1_exp + EW'(1) - EW'(lz);
	assign underflow = (int'(s1_exp) + 1 <= int'(lz));

	always_ff @(posedge iCLK) begin
		if (s1_a_zero && s1_b_zero)
			sum <= '0;
		else if (s1_a_zero)
			sum <= s1_b;
		else if (s1_b_zero)
			sum <= s1_a;
		else if (underflow || s1_sum == '0)
			sum <= '0;
		else
			sum <= {s1_sign, norm_exp, norm[ACC_W-2 -: FW]};
	end

endmodule

// ==== fp_inv_sqrt.sv ====
`timescale 1ns/10ps

module fp_inv_sqrt (
	input  logic             iCLK,
	input  fp_pkg::fp_word_u a,
	output fp_pkg::fp_word_u inv_sqrt
);
	logic [fp_pkg::FP_W-1:0] a_raw;
	fp_pkg::fp_word_u        guess;
	fp_pkg::fp_word_u        half_a;
	fp_pkg::fp_word_u        guess_sq;
	fp_pkg::fp_word_u        half_sq;
	fp_pkg::fp_word_u        neg_half_sq;
	fp_pkg::fp_word_u        corr;

	// Guess path registers, one per stage
	fp_pkg::fp_word_u        y_s1;
	fp_pkg::fp_word_u        y_s2;
	fp_pkg::fp_word_u        y_s3;
	fp_pkg::fp_word_u        y_s4;
	fp_pkg::fp_word_u        y_s5;

	// Side path registers
	fp_pkg::fp_word_u        half_s1;
	fp_pkg::fp_word_u        sq_s1;
	fp_pkg::fp_word_u        half_sq_s2;
	fp_pkg::fp_word_u        corr_s5;

	// Seed from the raw bits
	assign a_raw = a;
	assign guess = fp_pkg::INV_SQRT_MAGIC - (a_raw >> 1);

	// Halving is one off the exponent
	always_comb begin
		half_a            = a;
		half_a.fields.exp = a.fields.exp - 1'b1;
	end

	// y squared
	fp_mul u_sq (.a(guess), .b(guess), .prod(guess_sq));

	// a/2 times y squared
	fp_mul u_half_sq (.a(half_s1), .b(sq_s1), .prod(half_sq));

	always_comb begin
		neg_half_sq             = half_sq_s2;
		neg_half_sq.fields.sign = ~half_sq_s2.fields.sign;
	end

	// 1.5 minus that, two cycles
	fp_add u_corr (.iCLK(iCLK), .a(fp_pkg::FP_THREE_HALVES), .b(neg_half_sq), .sum(corr));

	// Newton step result
	fp_mul u_step (.a(y_s5), .b(corr_s5), .prod(inv_sqrt));

	always_ff @(posedge iCLK) begin
		y_s1       <= guess;
		half_s1    <= half_a;
		sq_s1      <= guess_sq;
		y_s2       <= y_s1;
		half_sq_s2 <= half_sq;
		y_s3       <= y_s2;
		// Adder busy for stages three and four
		y_s4       <= y_s3;
		y_s5       <= y_s4;
		corr_s5    <= corr;
	end

endmodule

// ==== fp_int_convert.sv ====
`timescale 1ns/10ps

module fp_int_convert (
	input  fp_pkg::fp_word_u a,
	output fp_pkg::fp_word_u to_fp,
	output fp_pkg::fp_word_u to_int
);
	localparam int EW    = fp_pkg::EXP_W;
	localparam int FW    = fp_pkg::FRAC_W;
	localparam int INT_W = 16;
	localparam int POS_W = $clog2(INT_W) + 1;
	// Integer part lands above the fraction bits
	localparam int BUF_W = INT_W + FW;
	localparam logic [INT_W-1:0] INT_MAX = 16'h7fff;

	logic signed [INT_W-1:0] int_in;
	logic [INT_W-1:0]        int_mag;
	logic [POS_W-1:0]        msb;
	logic [BUF_W-1:0]        fp_shift;
	logic [BUF_W-1:0]        int_shift;
	logic [INT_W-1:0]        int_mag_out;
	logic [INT_W-1:0]        int_out;

	// ======================================================================
	// Integer to float
	// ======================================================================

	always_comb begin
		int_in  = a.int_view.value;
		int_mag = int_in[INT_W-1] ? -int_in : int_in;
		// Leading one position
		msb = '0;
		for (int i = 0; i < INT_W; i++) begin
			if (int_mag[i])
				msb = POS_W'(i);
		end
		// Leading one moved to the hidden bit slot
		fp_shift = {{FW{1'b0}}, int_mag} << (POS_W'(FW) - msb);
		to_fp = '0;
		if (int_mag != '0) begin
			to_fp.fields.sign = int_in[INT_W-1];
			to_fp.fields.exp  = EW'(fp_pkg::EXP_BIAS) + EW'(msb);
			to_fp.fields.frac = fp_shift[FW-1:0];
		end
	end

	// ======================================================================
	// Float to integer
	// ======================================================================

	always_comb begin
		int_shift   = {{(INT_W-1){1'b0}}, 1'b1, a.fields.frac} <<
			(a.fields.exp - EW'(fp_pkg::EXP_BIAS));
		int_mag_out = int_shift[BUF_W-1 -: INT_W];
		// Below one truncates to zero, too large clips
		if (a.fields.exp < EW'(fp_pkg::EXP_BIAS))
			int_out = '0;
		else if (a.fields.exp > EW'(fp_pkg::FP_MAX_EXP_INT))
			int_out = a.fields.sign ? -INT_MAX : INT_MAX;
		else
			int_out = a.fields.sign ? -int_mag_out : int_mag_out;
		to_int = '0;
		to_int.int_view.value = int_out;
	end

endmodule

// ==== fpu_exec.sv ====
`timescale 1ns/10ps

module fpu_exec (
	input logic    iCLK,
	input logic    reset_key,
	fpu_op_if.exec op_if
);
	// Countdown wide enough for the longest op
	localparam int CNT_W = $clog2(fp_pkg::INV_SQRT_LATENCY + 2);

	fp_pkg::fp_word_u      add_b;
	fp_pkg::fp_word_u      add_sum;
	fp_pkg::fp_word_u      mul_prod;
	fp_pkg::fp_word_u      isqrt_out;
	fp_pkg::fp_word_u      to_fp;
	fp_pkg::fp_word_u      to_int;
	fp_pkg::fp_word_u      unit_out;
	fpu_regs_pkg::fpu_op_e op_q;
	fpu_regs_pkg::fpu_op_e sel_op;
	logic [CNT_W-1:0]      cnt;
	logic [CNT_W-1:0]      op_lat;
	logic                  capture;

	// Subtract is add with B negated
	always_comb begin
		add_b = op_if.b;
		if (op_if.op == fpu_regs_pkg::OP_SUB)
			add_b.fields.sign = ~op_if.b.fields.sign;
	end

	// Units see operands in the start cycle only
	fp_add         u_add   (.iCLK(iCLK), .a(op_if.a), .b(add_b), .sum(add_sum));
	fp_mul         u_mul   (.a(op_if.a), .b(op_if.b), .prod(mul_prod));
	fp_inv_sqrt    u_isqrt (.iCLK(iCLK), .a(op_if.a), .inv_sqrt(isqrt_out));
	fp_int_convert u_conv  (.a(op_if.a), .to_fp(to_fp), .to_int(to_int));

	// Cycles from start to done
	always_comb begin
		case (op_if.op)
			fpu_regs_pkg::OP_ADD,
			fpu_regs_pkg::OP_SUB:      op_lat = CNT_W'(fp_pkg::ADD_LATENCY + 1);
			fpu_regs_pkg::OP_INV_SQRT: op_lat = CNT_W'(fp_pkg::INV_SQRT_LATENCY + 1);
			default:                   op_lat = CNT_W'(1);
		endcase
	end

	// Combinational ops are taken in the start cycle itself
	assign sel_op = op_if.start ? op_if.op : op_q;

	always_comb begin
		case (sel_op)
			fpu_regs_pkg::OP_ADD,
			fpu_regs_pkg::OP_SUB:      unit_out = add_sum;
			fpu_regs_pkg::OP_MUL:      unit_out = mul_prod;
			fpu_regs_pkg::OP_INV_SQRT: unit_out = isqrt_out;
			fpu_regs_pkg::OP_INT2FP:   unit_out = to_fp;
			fpu_regs_pkg::OP_FP2INT:   unit_out = to_int;
			default:                   unit_out = '0;
		endcase
	end

	// Result is loaded the cycle before done
	assign capture = (op_if.start && op_lat == CNT_W'(1)) || (cnt == CNT_W'(2));

	always_ff @(posedge iCLK) begin
		if (reset_key) begin
			cnt  <= '0;
			op_q <= fpu_regs_pkg::OP_ADD;
		end else if (op_if.start) begin
			cnt  <= op_lat;
			op_q <= op_if.op;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	always_ff @(posedge iCLK) begin
		if (capture)
			op_if.result <= unit_out;
	end

	// Busy through the done cycle, both drop together
	assign op_if.busy = (cnt != '0);
	assign op_if.done = (cnt == CNT_W'(1));

endmodule

// ==== fpu_apb_regs.sv ====
`timescale 1ns/10ps

module fpu_apb_regs #(
	parameter int ADDR_W = 8
) (
	input  logic              iCLK,
	input  logic              reset_key,
	input  logic [ADDR_W-1:0] paddr,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	fpu_op_if.regs            op_if
);
	localparam int OP_W = $bits(fpu_regs_pkg::fpu_op_e);

	logic                  sel_opa;
	logic                  sel_opb;
	logic                  sel_ctrl;
	logic                  sel_status;
	logic                  sel_result;
	logic                  mapped;
	logic                  access;
	logic                  ctrl_stall;
	logic                  wr_done;
	logic                  start_q;
	logic                  done_flag;
	logic [31:0]           status_w;
	fpu_regs_pkg::fpu_op_e ctrl_op;
	fp_pkg::fp_word_u      opa_q;
	fp_pkg::fp_word_u      opb_q;
	fp_pkg::fp_word_u      result_q;

	// ======================================================================
	// Address decode and APB handshake
	// ======================================================================

	assign sel_opa    = (paddr == ADDR_W'(fpu_regs_pkg::REG_OPA));
	assign sel_opb    = (paddr == ADDR_W'(fpu_regs_pkg::REG_OPB));
	assign sel_ctrl   = (paddr == ADDR_W'(fpu_regs_pkg::REG_CTRL));
	assign sel_status = (paddr == ADDR_W'(fpu_regs_pkg::REG_STATUS));
	assign sel_result = (paddr == ADDR_W'(fpu_regs_pkg::REG_RESULT));
	assign mapped     = sel_opa | sel_opb | sel_ctrl | sel_status | sel_result;

	// Access phase
	assign access = psel && penable;

	// New op waits for the running one
	assign ctrl_stall = access && pwrite && sel_ctrl && op_if.busy;
	assign pready     = !ctrl_stall;
	assign pslverr    = access && !mapped;

	// Completing write to a real register
	assign wr_done = access && pwrite && pready && mapped;

	// ======================================================================
	// Registers
	// ======================================================================

	always_ff @(posedge iCLK) begin
		if (reset_key) begin
			start_q   <= 1'b0;
			ctrl_op   <= fpu_regs_pkg::OP_ADD;
			done_flag <= 1'b0;
			result_q  <= '0;
		end else begin
			// One-cycle issue pulse after the CTRL write
			start_q <= wr_done && sel_ctrl;
			if (wr_done && sel_ctrl)
				ctrl_op <= fpu_regs_pkg::fpu_op_e'(pwdata[OP_W-1:0]);
			// Sticky done, cleared by the next op
			if (op_if.done) begin
				done_flag <= 1'b1;
				result_q  <= op_if.result;
			end else if (wr_done && sel_ctrl) begin
				done_flag <= 1'b0;
			end
		end
	end

	// Operands
	always_ff @(posedge iCLK) begin
		if (wr_done && sel_opa)
			opa_q <= pwdata[fp_pkg::FP_W-1:0];
		if (wr_done && sel_opb)
			opb_q <= pwdata[fp_pkg::FP_W-1:0];
	end

	assign op_if.start = start_q;
	assign op_if.op    = ctrl_op;
	assign op_if.a     = opa_q;
	assign op_if.b     = opb_q;

	// Read mux, zero extended
	always_comb begin
		status_w = '0;
		status_w[fpu_regs_pkg::STATUS_BUSY_BIT] = op_if.busy;
		status_w[fpu_regs_pkg::STATUS_DONE_BIT] = done_flag;
		prdata = '0;
		if (sel_opa)
			prdata = 32'(opa_q);
		else if (sel_opb)
			prdata = 32'(opb_q);
		else if (sel_ctrl)
			prdata = 32'(ctrl_op);
		else if (sel_status)
			prdata = status_w;
		else if (sel_result)
			prdata = 32'(result_q);
	end

endmodule

// ==== fpu_top.sv ====
`timescale 1ns/10ps

module fpu_top #(
	parameter int ADDR_W = 8
) (
	input  logic              iCLK,
	input  logic              reset_key,
	// APB3 slave
	input  logic [ADDR_W-1:0] paddr,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr
);

	// Issue path between register block and execution unit
	fpu_op_if op_if ();

	fpu_apb_regs #(
		.ADDR_W(ADDR_W)
	) u_regs (
		.iCLK      (iCLK),
		.reset_key (reset_key),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.op_if     (op_if.regs)
	);

	// Arithmetic units and latency tracking
	fpu_exec u_exec (
		.iCLK      (iCLK),
		.reset_key (reset_key),
		.op_if     (op_if.exec)
	);

endmodule

// ==== fpu_assert.sv ====
`timescale 1ns/10ps

module fpu_assert #(
	parameter int ADDR_W = 8
) (
	input logic              iCLK,
	input logic              reset_key,
	input logic [ADDR_W-1:0] paddr,
	input logic              psel,
	input logic              penable,
	input logic              pwrite,
	input logic              pready,
	input logic              pslverr,
	input logic              busy,
	input logic              done,
	input logic              start
);

	// Error flagged only in a completing access cycle
	a_slverr_in_access: assert property (@(posedge iCLK) disable iff (reset_key)
		pslverr |-> (psel && penable && pready))
		else $error("pslverr outside a completing access cycle");

	// Wait states only for a CTRL write during a running op, released after done
	a_wait_only_ctrl_busy: assert property (@(posedge iCLK) disable iff (reset_key)
		!pready |=> ($past(psel && penable && pwrite && busy &&
			paddr == ADDR_W'(fpu_regs_pkg::REG_CTRL)) && pready == $past(done)))
		else $error("pready low outside a CTRL write while busy, or held past done");

	// Issue only into an idle unit
	a_start_idle: assert property (@(posedge iCLK) disable iff (reset_key)
		$rose(start) |-> !busy)
		else $error("start raised while busy");

	// Single-cycle issue pulse
	a_start_pulse: assert property (@(posedge iCLK) disable iff (reset_key)
		start |=> !start)
		else $error("start held longer than one cycle");

endmodule

// ==== tb_fpu.sv ====
`timescale 1ns/10ps

module tb_fpu;

	localparam int ADDR_W = 8;
	// Operations issued over all tests, sizes the watchdog
	localparam int TEST_COUNT      = 52;
	localparam int WATCHDOG_CYCLES = TEST_COUNT * 200 + 1000;
	localparam int POLL_LIMIT      = 50;
	localparam int NUM_RANDOM      = 8;
	// 0.5% of the value, in fraction LSBs
	localparam int ISQRT_TOL       = 1310;

	localparam logic [ADDR_W-1:0] A_OPA    = ADDR_W'(fpu_regs_pkg::REG_OPA);
	localparam logic [ADDR_W-1:0] A_OPB    = ADDR_W'(fpu_regs_pkg::REG_OPB);
	localparam logic [ADDR_W-1:0] A_CTRL   = ADDR_W'(fpu_regs_pkg::REG_CTRL);
	localparam logic [ADDR_W-1:0] A_STATUS = ADDR_W'(fpu_regs_pkg::REG_STATUS);
	localparam logic [ADDR_W-1:0] A_RESULT = ADDR_W'(fpu_regs_pkg::REG_RESULT);
	// First address past the register map
	localparam logic [ADDR_W-1:0] A_UNMAPPED = ADDR_W'(8'h14);

	logic              iCLK;
	logic              reset_key;
	logic [ADDR_W-1:0] paddr;
	logic              psel;
	logic              penable;
	logic              pwrite;
	logic [31:0]       pwdata;
	logic [31:0]       prdata;
	logic              pready;
	logic              pslverr;

	int checks;
	int mismatches;
	int failures;

	fpu_top #(
		.ADDR_W(ADDR_W)
	) UUT (
		.iCLK      (iCLK),
		.reset_key (reset_key),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr)
	);

	// Protocol and issue rules watched inside the DUT
	bind fpu_top fpu_assert #(
		.ADDR_W(ADDR_W)
	) u_assert (
		.iCLK      (iCLK),
		.reset_key (reset_key),
		.paddr     (paddr),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pready    (pready),
		.pslverr   (pslverr),
		.busy      (op_if.busy),
		.done      (op_if.done),
		.start     (op_if.start)
	);

	// 40 ns period
	always #20 iCLK = ~iCLK;

	// ======================================================================
	// Operand builders and compare tasks
	// ======================================================================

	function automatic fp_pkg::fp_word_u make_fp(input logic sign, input logic [7:0] exp_b,
			input logic [17:0] frac);
		fp_pkg::fp_word_u w;
		w.fields.sign = sign;
		w.fields.exp  = exp_b;
		w.fields.frac = frac;
		return w;
	endfunction

	// Integer in the low 16 bits, pad cleared
	function automatic fp_pkg::fp_word_u make_int(input logic signed [15:0] v);
		fp_pkg::fp_word_u w;
		w = '0;
		w.int_view.value = v;
		return w;
	endfunction

	// Exponent and fraction together are monotonic in magnitude
	task automatic check_fp(input string name, input fp_pkg::fp_word_u got,
			input fp_pkg::fp_word_u want, input int tol);
		int diff;
		checks++;
		diff = int'({got.fields.exp, got.fields.frac}) - int'({want.fields.exp, want.fields.frac});
		if (diff < 0)
			diff = -diff;
		if ($isunknown(got) || got.fields.sign !== want.fields.sign || diff > tol) begin
			mismatches++;
			$display("mismatch %s: got 0x%07h expected 0x%07h (tolerance %0d LSB)",
				name, got, want, tol);
		end
	endtask

	task automatic check_int(input string name, input logic signed [15:0] got,
			input logic signed [15:0] want);
		checks++;
		if (got !== want) begin
			mismatches++;
			$display("mismatch %s: got 0x%04h expected 0x%04h", name, got, want);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			mismatches++;
			$display("mismatch %s: got 0x%0h expected 0x%0h", name, got, want);
		end
	endtask

	// ======================================================================
	// APB transfers
	// ======================================================================

	task automatic apb_access(input logic [ADDR_W-1:0] addr, input logic write,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err,
			output int waits);
		waits = 0;
		// Setup phase
		@(posedge iCLK);
		#2;
		paddr   = addr;
		pwrite  = write;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;
		// Access phase
		@(posedge iCLK);
		#2;
		penable = 1'b1;
		// Ready and data settled by mid-cycle
		@(negedge iCLK);
		while (!pready) begin
			waits++;
			@(negedge iCLK);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge iCLK);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		int          waits;
		apb_access(addr, 1'b1, data, rd, err, waits);
		check_flag("pslverr on write", err, 1'b0);
	endtask

	task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
		logic err;
		int   waits;
		apb_access(addr, 1'b0, 32'h0, data, err, waits);
		check_flag("pslverr on read", err, 1'b0);
	endtask

	// Polls STATUS until the done bit is set
	task automatic wait_done(output logic ok);
		logic [31:0] status;
		int          polls;
		ok    = 1'b0;
		polls = 0;
		while (!ok && polls < POLL_LIMIT) begin
			apb_read(A_STATUS, status);
			ok = status[fpu_regs_pkg::STATUS_DONE_BIT];
			polls++;
		end
		if (!ok) begin
			failures++;
			$display("Operation never reported done after %0d STATUS polls", POLL_LIMIT);
		end
	endtask

	task automatic run_op(input fpu_regs_pkg::fpu_op_e op, input fp_pkg::fp_word_u a,
			input fp_pkg::fp_word_u b, output fp_pkg::fp_word_u res);
		logic [31:0] rd;
		logic        ok;
		apb_write(A_OPA, 32'(a));
		apb_write(A_OPB, 32'(b));
		apb_write(A_CTRL, 32'(op));
		wait_done(ok);
		apb_read(A_RESULT, rd);
		res = rd[fp_pkg::FP_W-1:0];
	endtask

	// ======================================================================
	// Directed tests
	// ======================================================================

	task automatic test_reset_state();
		logic [31:0] rd;
		check_flag("pready after reset", pready, 1'b1);
		check_flag("pslverr after reset", pslverr, 1'b0);
		apb_read(A_STATUS, rd);
		check_flag("status busy after reset", rd[fpu_regs_pkg::STATUS_BUSY_BIT], 1'b0);
		check_flag("status done after reset", rd[fpu_regs_pkg::STATUS_DONE_BIT], 1'b0);
		apb_read(A_RESULT, rd);
		check_fp("result after reset", rd[fp_pkg::FP_W-1:0], '0, 0);
	endtask

	task automatic test_int_roundtrip();
		logic signed [15:0] vals[$];
		fp_pkg::fp_word_u   f;
		fp_pkg::fp_word_u   back;
		int                 r;
		vals = '{16'sd0, 16'sd1, -16'sd1, 16'sd5, -16'sd5, 16'sd100, -16'sd1234,
			16'sd1024, 16'sd32767, -16'sd32767};
		// Random integers clear of the one that cannot be negated
		for (int i = 0; i < NUM_RANDOM; i++) begin
			r = int'($urandom % 32'd65535) - 32767;
			vals.push_back(r[15:0]);
		end
		foreach (vals[i]) begin
			run_op(fpu_regs_pkg::OP_INT2FP, make_int(vals[i]), '0, f);
			// 5 is 1.25 times 4
			if (vals[i] == 16'sd5)
				check_fp("int2fp of 5", f, make_fp(1'b0, 8'd129, 18'h10000), 0);
			run_op(fpu_regs_pkg::OP_FP2INT, f, '0, back);
			check_int("fp2int roundtrip", back.int_view.value, vals[i]);
		end
	endtask

	task automatic test_arith();
		fp_pkg::fp_word_u r;
		// 1.5 + 2.25 = 3.75
		run_op(fpu_regs_pkg::OP_ADD, make_fp(1'b0, 8'd127, 18'h20000),
			make_fp(1'b0, 8'd128, 18'h08000), r);
		check_fp("add 1.5 2.25", r, make_fp(1'b0, 8'd128, 18'h38000), 0);
		// 3.0 - 5.0 = -2.0
		run_op(fpu_regs_pkg::OP_SUB, make_fp(1'b0, 8'd128, 18'h20000),
			make_fp(1'b0, 8'd129, 18'h10000), r);
		check_fp("sub 3.0 5.0", r, make_fp(1'b1, 8'd128, 18'h00000), 0);
		// 2.5 * 3.0 = 7.5
		run_op(fpu_regs_pkg::OP_MUL, make_fp(1'b0, 8'd128, 18'h10000),
			make_fp(1'b0, 8'd128, 18'h20000), r);
		check_fp("mul 2.5 3.0", r, make_fp(1'b0, 8'd129, 18'h38000), 0);
		run_op(fpu_regs_pkg::OP_MUL, make_fp(1'b0, 8'd128, 18'h00000), '0, r);
		check_fp("mul 2.0 zero", r, '0, 0);
		// Zero on either side passes the other operand
		run_op(fpu_regs_pkg::OP_ADD, make_fp(1'b0, 8'd127, 18'h20000), '0, r);
		check_fp("add 1.5 zero", r, make_fp(1'b0, 8'd127, 18'h20000), 0);
		run_op(fpu_regs_pkg::OP_ADD, '0, make_fp(1'b1, 8'd128, 18'h00000), r);
		check_fp("add zero -2.0", r, make_fp(1'b1, 8'd128, 18'h00000), 0);
	endtask

	task automatic test_inv_sqrt();
		fp_pkg::fp_word_u r;
		run_op(fpu_regs_pkg::OP_INV_SQRT, make_fp(1'b0, 8'd129, 18'h0), '0, r);
		check_fp("inv_sqrt 4", r, make_fp(1'b0, 8'd126, 18'h0), ISQRT_TOL);
		run_op(fpu_regs_pkg::OP_INV_SQRT, make_fp(1'b0, 8'd131, 18'h0), '0, r);
		check_fp("inv_sqrt 16", r, make_fp(1'b0, 8'd125, 18'h0), ISQRT_TOL);
		run_op(fpu_regs_pkg::OP_INV_SQRT, make_fp(1'b0, 8'd125, 18'h0), '0, r);
		check_fp("inv_sqrt 0.25", r, make_fp(1'b0, 8'd128, 18'h0), ISQRT_TOL);
	endtask

	task automatic test_saturate();
		fp_pkg::fp_word_u r;
		// 2 to the 20th is past the 16-bit range
		run_op(fpu_regs_pkg::OP_FP2INT, make_fp(1'b0, 8'd147, 18'h0), '0, r);
		check_int("fp2int 2^20", r.int_view.value, 16'sd32767);
		run_op(fpu_regs_pkg::OP_FP2INT, make_fp(1'b1, 8'd147, 18'h0), '0, r);
		check_int("fp2int -2^20", r.int_view.value, -16'sd32767);
		run_op(fpu_regs_pkg::OP_FP2INT, make_fp(1'b0, 8'd126, 18'h0), '0, r);
		check_int("fp2int 0.5", r.int_view.value, 16'sd0);
	endtask

	task automatic test_done_flag();
		fp_pkg::fp_word_u r;
		logic [31:0]      rd;
		logic             ok;
		// 2.0 * 3.0 = 6.0
		run_op(fpu_regs_pkg::OP_MUL, make_fp(1'b0, 8'd128, 18'h0),
			make_fp(1'b0, 8'd128, 18'h20000), r);
		check_fp("mul 2.0 3.0", r, make_fp(1'b0, 8'd129, 18'h20000), 0);
		apb_read(A_STATUS, rd);
		check_flag("status done after op", rd[fpu_regs_pkg::STATUS_DONE_BIT], 1'b1);
		check_flag("status busy after op", rd[fpu_regs_pkg::STATUS_BUSY_BIT], 1'b0);
		// Long op, done must stay clear while it runs
		apb_write(A_CTRL, 32'(fpu_regs_pkg::OP_INV_SQRT));
		apb_read(A_STATUS, rd);
		check_flag("status done after CTRL write", rd[fpu_regs_pkg::STATUS_DONE_BIT], 1'b0);
		wait_done(ok);
	endtask

	task automatic test_stall();
		logic [31:0] rd;
		logic        err;
		logic        ok;
		int          waits;
		apb_write(A_OPA, 32'(make_fp(1'b0, 8'd129, 18'h0)));
		apb_write(A_OPB, 32'(make_fp(1'b0, 8'd128, 18'h10000)));
		apb_write(A_CTRL, 32'(fpu_regs_pkg::OP_INV_SQRT));
		// Second op lands while the first is busy
		apb_access(A_CTRL, 1'b1, 32'(fpu_regs_pkg::OP_ADD), rd, err, waits);
		check_flag("pready wait states on busy CTRL", waits > 0, 1'b1);
		check_flag("pslverr on stalled write", err, 1'b0);
		// Add is still running, RESULT holds the first op
		apb_read(A_RESULT, rd);
		check_fp("inv_sqrt before stalled op", rd[fp_pkg::FP_W-1:0],
			make_fp(1'b0, 8'd126, 18'h0), ISQRT_TOL);
		wait_done(ok);
		apb_read(A_RESULT, rd);
		// 4.0 + 2.5 = 6.5
		check_fp("add after stall", rd[fp_pkg::FP_W-1:0], make_fp(1'b0, 8'd129, 18'h28000), 0);
	endtask

	task automatic test_unmapped();
		logic [31:0] rd;
		logic        err;
		int          waits;
		// Known operands, 2.0 and -1.0
		apb_write(A_OPA, 32'(make_fp(1'b0, 8'd128, 18'h0)));
		apb_write(A_OPB, 32'(make_fp(1'b1, 8'd127, 18'h0)));
		apb_access(A_UNMAPPED, 1'b1, 32'h07ff_ffff, rd, err, waits);
		check_flag("pslverr on unmapped write", err, 1'b1);
		apb_access(A_UNMAPPED, 1'b0, 32'h0, rd, err, waits);
		check_flag("pslverr on unmapped read", err, 1'b1);
		// 0x14 shares its low address bits with OPB
		apb_read(A_OPA, rd);
		check_fp("OPA after unmapped write", rd[fp_pkg::FP_W-1:0],
			make_fp(1'b0, 8'd128, 18'h0), 0);
		apb_read(A_OPB, rd);
		check_fp("OPB after unmapped write", rd[fp_pkg::FP_W-1:0],
			make_fp(1'b1, 8'd127, 18'h0), 0);
	endtask

	// ======================================================================
	// Main sequence and watchdog
	// ======================================================================

	initial begin
		void'($urandom(53));
		iCLK       = 1'b0;
		reset_key  = 1'b1;
		paddr      = '0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		pwdata     = '0;
		checks     = 0;
		mismatches = 0;
		failures   = 0;
		repeat (8) @(posedge iCLK);
		#2;
		reset_key = 1'b0;
		test_reset_state();
		test_int_roundtrip();
		test_arith();
		test_inv_sqrt();
		test_saturate();
		test_done_flag();
		test_stall();
		test_unmapped();
		$display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge iCLK);
		$display("Watchdog expired after %0d cycles, the DUT stopped responding",
			WATCHDOG_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== src.f ====
fp_pkg.sv
fpu_regs_pkg.sv
fpu_op_if.sv
fp_mul.sv
fp_add.sv
fp_inv_sqrt.sv
fp_int_convert.sv
fpu_exec.sv
fpu_apb_regs.sv
fpu_top.sv
fpu_assert.sv
tb_fpu.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the FPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_fpu -o tb_fpu
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

output=$(./obj_dir/tb_fpu)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1
